//--- all.f
hw/memPkg.sv
hw/wordStore.sv
hw/burstEngine.sv
hw/cacheArbiter.sv
hw/memSubsystem.sv
verif/memSubsystem_properties.sv
verif/memSubsystemTb.sv

//--- verif/memSubsystemTb.sv
module memSubsystemTb;
	timeunit 1ns;
	timeprecision 1ps;
	import memPkg::*;

	localparam int Timeout = 500;
	localparam int RandTimeout = 5000;
	localparam int NumRandOps = 40;
	localparam int WinBase = 512;
	localparam int WinSize = 32;

	logic clk;
	logic rst;
	wordAddr_t [NumCaches-1:0] addr;
	dataWord_t [NumCaches-1:0] writeData;
	burstLen_t [NumCaches-1:0] transSize;
	logic [NumCaches-1:0] readReq;
	logic [NumCaches-1:0] writeReq;
	logic [NumCaches-1:0] readValid;
	dataWord_t [NumCaches-1:0] readData;
	logic [NumCaches-1:0] writeAdvance;
	logic [NumCaches-1:0] doneRead;
	logic [NumCaches-1:0] doneWrite;

	// Reference copy of the store, with the same address aliasing
	dataWord_t refMem [0:(1 << StoreDepthLog)-1];
	logic [31:0] lcgState;

	// What each cache has requested and how far it has got
	logic active [NumCaches];
	logic opWrite [NumCaches];
	wordAddr_t opBase [NumCaches];
	int opLen [NumCaches];
	int rdIdx [NumCaches];
	int wrIdx [NumCaches];
	dataWord_t wrWords [NumCaches][MaxTrans];
	dataWord_t lastRead [NumCaches];
	// Completions of other caches seen while a cache waits
	int waitCnt [NumCaches][NumCaches];
	int owner;
	int doneOrder [$];
	int errorCount;

	memSubsystem u_dut (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.writeData(writeData),
		.transSize(transSize),
		.readReq(readReq),
		.writeReq(writeReq),
		.readValid(readValid),
		.readData(readData),
		.writeAdvance(writeAdvance),
		.doneRead(doneRead),
		.doneWrite(doneWrite)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int storeIndex(input wordAddr_t a);
		return int'(a[StoreDepthLog-1:0]);
	endfunction

	function automatic bit anyActive();
		for (int c = 0; c < NumCaches; c++) begin
			if (active[c]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic stopOnError(input string why);
		errorCount++;
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			stopOnError($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// All strobes between two done pulses must belong to one cache
	task automatic claimStrobe(input int c);
		if (owner < 0) begin
			owner = c;
		end
		assert (owner == c) else begin
			stopOnError($sformatf("strobe on cache %0d while cache %0d is served", c, owner));
		end
	endtask

	task automatic raiseReq(input int c, input bit isWr, input wordAddr_t base, input int len);
		opWrite[c] = isWr;
		opBase[c] = base;
		opLen[c] = len;
		rdIdx[c] = 0;
		wrIdx[c] = 0;
		active[c] = 1'b1;
		if (isWr) begin
			for (int k = 0; k < len; k++) begin
				wrWords[c][k] = nextRand();
			end
		end
		for (int d = 0; d < NumCaches; d++) begin
			waitCnt[c][d] = 0;
		end
		addr[c] = base;
		transSize[c] = burstLen_t'(len);
		writeData[c] = isWr ? wrWords[c][0] : '0;
		readReq[c] = !isWr;
		writeReq[c] = isWr;
	endtask

	task automatic finishTrans(input int c);
		assert (active[c] && doneWrite[c] == opWrite[c] && owner == c) else begin
			stopOnError($sformatf("unexpected done pulse on cache %0d", c));
		end
		checkValue($sformatf("beat count of cache %0d", c),
			opWrite[c] ? wrIdx[c] : rdIdx[c], opLen[c]);
		for (int d = 0; d < NumCaches; d++) begin
			if (active[d] && d != c) begin
				waitCnt[d][c]++;
				assert (waitCnt[d][c] < 2) else begin
					stopOnError($sformatf("cache %0d served twice while cache %0d waited", c, d));
				end
			end
		end
		readReq[c] = 1'b0;
		writeReq[c] = 1'b0;
		active[c] = 1'b0;
		owner = -1;
		doneOrder.push_back(c);
	endtask

	task automatic observe();
		for (int c = 0; c < NumCaches; c++) begin
			if (readValid[c]) begin
				claimStrobe(c);
				assert (active[c] && !opWrite[c] && rdIdx[c] < opLen[c]) else begin
					stopOnError($sformatf("unexpected readValid on cache %0d", c));
				end
				checkValue($sformatf("readData[%0d]", c), readData[c],
					refMem[storeIndex(opBase[c] + rdIdx[c])]);
				lastRead[c] = readData[c];
				rdIdx[c]++;
			end
			if (writeAdvance[c]) begin
				claimStrobe(c);
				assert (active[c] && opWrite[c] && wrIdx[c] < opLen[c]) else begin
					stopOnError($sformatf("unexpected writeAdvance on cache %0d", c));
				end
				refMem[storeIndex(opBase[c] + wrIdx[c])] = wrWords[c][wrIdx[c]];
				wrIdx[c]++;
				// Next word is shown before the engine samples it at the rising edge
				writeData[c] = (wrIdx[c] < opLen[c]) ? wrWords[c][wrIdx[c]] : '0;
			end
			if (doneRead[c] || doneWrite[c]) begin
				finishTrans(c);
			end
		end
	endtask

	task automatic step();
		@(negedge clk);
		observe();
	endtask

	task automatic waitDone(input int c, output int cycles);
		cycles = 0;
		while (active[c]) begin
			step();
			cycles++;
			assert (cycles < Timeout) else begin
				stopOnError($sformatf("timeout waiting for the done pulse of cache %0d", c));
			end
		end
	endtask

	task automatic waitAllIdle();
		int cycles;
		cycles = 0;
		while (anyActive()) begin
			step();
			cycles++;
			assert (cycles < Timeout) else begin
				stopOnError("timeout waiting for all caches to finish");
			end
		end
	endtask

	task automatic singleRoundTrip();
		int cycles;
		raiseReq(0, 1'b1, wordAddr_t'(100), 1);
		waitDone(0, cycles);
		raiseReq(0, 1'b0, wordAddr_t'(100), 1);
		waitDone(0, cycles);
		checkValue("readData[0] of the round trip", lastRead[0], wrWords[0][0]);
	endtask

	task automatic burstWriteRead();
		int cycles;
		raiseReq(2, 1'b1, wordAddr_t'(200), 16);
		waitDone(2, cycles);
		checkValue("writeAdvance count", wrIdx[2], 16);
		raiseReq(2, 1'b0, wordAddr_t'(200), 16);
		waitDone(2, cycles);
		checkValue("readValid count", rdIdx[2], 16);
	endtask

	// Each request is raised in the done cycle of the cache just before it
	task automatic exactLatency();
		int cycles;
		raiseReq(0, 1'b0, wordAddr_t'(100), 1);
		waitDone(0, cycles);
		raiseReq(1, 1'b0, wordAddr_t'(200), 4);
		waitDone(1, cycles);
		checkValue("doneRead latency", cycles, 4 + ReadLatency + 1);
		raiseReq(2, 1'b1, wordAddr_t'(300), 3);
		waitDone(2, cycles);
		checkValue("doneWrite latency", cycles, 3 + 1);
	endtask

	task automatic roundRobinFromReset();
		@(negedge clk);
		rst = 1'b1;
		owner = -1;
		doneOrder.delete();
		for (int c = 0; c < NumCaches; c++) begin
			raiseReq(c, 1'b0, wordAddr_t'(200 + 2 * c), 2);
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;
		waitAllIdle();
		checkValue("number of done pulses", doneOrder.size(), NumCaches);
		for (int k = 0; k < NumCaches; k++) begin
			checkValue($sformatf("cache of done pulse %0d", k), doneOrder[k], k);
		end
	endtask

	task automatic randomTraffic();
		logic [31:0] r;
		wordAddr_t base;
		int issued;
		int cycles;
		// Fill the window so that every random read hits known data
		raiseReq(3, 1'b1, wordAddr_t'(WinBase), WinSize);
		waitDone(3, cycles);
		issued = 0;
		cycles = 0;
		while (issued < NumRandOps || anyActive()) begin
			step();
			cycles++;
			assert (cycles < RandTimeout) else begin
				stopOnError("timeout in the random traffic test");
			end
			for (int c = 0; c < NumCaches; c++) begin
				r = nextRand();
				if (!active[c] && issued < NumRandOps && r[31:30] == 2'b00) begin
					r = nextRand();
					// Random upper bits alias onto the window
					base = (wordAddr_t'(r[14:0]) << StoreDepthLog)
						| wordAddr_t'(WinBase + r[23:19] % 25);
					raiseReq(c, r[27], base, 1 + int'(r[18:16]));
					issued++;
				end
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		addr = '0;
		writeData = '0;
		transSize = '0;
		readReq = '0;
		writeReq = '0;
		lcgState = 32'd53834;
		owner = -1;
		errorCount = 0;
		for (int c = 0; c < NumCaches; c++) begin
			active[c] = 1'b0;
			opWrite[c] = 1'b0;
			opBase[c] = '0;
			opLen[c] = 0;
			rdIdx[c] = 0;
			wrIdx[c] = 0;
			lastRead[c] = '0;
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;
		singleRoundTrip();
		burstWriteRead();
		exactLatency();
		roundRobinFromReset();
		randomTraffic();
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- verif/memSubsystem_properties.sv
module memSubsystemProperties (
	input logic clk,
	input logic rst,
	input logic [memPkg::NumCaches-1:0] readReq,
	input logic [memPkg::NumCaches-1:0] readValid,
	input logic [memPkg::NumCaches-1:0] doneRead,
	input logic [memPkg::NumCaches-1:0] doneWrite
);
	timeunit 1ns;
	timeprecision 1ps;

	// Only one transaction can complete per cycle
	doneOneHot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(doneRead | doneWrite))
		else $error("more than one done bit set in one cycle");

	// Read words go only to a cache that is asking for them
	readValidRequested: assert property (@(posedge clk) disable iff (rst)
		(readValid & ~readReq) == '0)
		else $error("readValid set for a cache without a read request");

	doneKindsExclusive: assert property (@(posedge clk) disable iff (rst)
		!((|doneRead) && (|doneWrite)))
		else $error("doneRead and doneWrite set in the same cycle");

endmodule

bind memSubsystem memSubsystemProperties u_props (
	.clk(clk),
	.rst(rst),
	.readReq(readReq),
	.readValid(readValid),
	.doneRead(doneRead),
	.doneWrite(doneWrite)
);

//--- hw/memSubsystem.sv
module memSubsystem (
	input  logic clk,
	input  logic rst,
	input  memPkg::wordAddr_t [memPkg::NumCaches-1:0] addr,
	input  memPkg::dataWord_t [memPkg::NumCaches-1:0] writeData,
	input  memPkg::burstLen_t [memPkg::NumCaches-1:0] transSize,
	input  logic [memPkg::NumCaches-1:0] readReq,
	input  logic [memPkg::NumCaches-1:0] writeReq,
	output logic [memPkg::NumCaches-1:0] readValid,
	output memPkg::dataWord_t [memPkg::NumCaches-1:0] readData,
	output logic [memPkg::NumCaches-1:0] writeAdvance,
	output logic [memPkg::NumCaches-1:0] doneRead,
	output logic [memPkg::NumCaches-1:0] doneWrite
);
	import memPkg::*;

	// Arbiter and engine handshake
	logic cmdStart;
	burstCmd_t cmd;
	dataWord_t curWriteData;
	logic rdBeat;
	dataWord_t rdData;
	logic wrTaken;
	logic burstDone;

	// Engine and store
	logic storeEn;
	storeReq_t storeReq;
	logic rdValid;
	dataWord_t storeRdData;

	cacheArbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.writeData(writeData),
		.transSize(transSize),
		.readReq(readReq),
		.writeReq(writeReq),
		.rdBeat(rdBeat),
		.rdData(rdData),
		.wrTaken(wrTaken),
		.burstDone(burstDone),
		.readValid(readValid),
		.readData(readData),
		.writeAdvance(writeAdvance),
		.doneRead(doneRead),
		.doneWrite(doneWrite),
		.cmdStart(cmdStart),
		.cmd(cmd),
		.curWriteData(curWriteData)
	);

	burstEngine u_engine (
		.clk(clk),
		.rst(rst),
		.cmdStart(cmdStart),
		.cmd(cmd),
		.curWriteData(curWriteData),
		.rdValid(rdValid),
		.storeRdData(storeRdData),
		.storeEn(storeEn),
		.storeReq(storeReq),
		.rdBeat(rdBeat),
		.rdData(rdData),
		.wrTaken(wrTaken),
		.burstDone(burstDone)
	);

	wordStore u_store (
		.clk(clk),
		.rst(rst),
		.storeEn(storeEn),
		.storeReq(storeReq),
		.rdValid(rdValid),
		.rdData(storeRdData)
	);

endmodule

//--- hw/cacheArbiter.sv
module cacheArbiter (
	input  logic clk,
	input  logic rst,
	input  memPkg::wordAddr_t [memPkg::NumCaches-1:0] addr,
	input  memPkg::dataWord_t [memPkg::NumCaches-1:0] writeData,
	input  memPkg::burstLen_t [memPkg::NumCaches-1:0] transSize,
	input  logic [memPkg::NumCaches-1:0] readReq,
	input  logic [memPkg::NumCaches-1:0] writeReq,
	input  logic rdBeat,
	input  memPkg::dataWord_t rdData,
	input  logic wrTaken,
	input  logic burstDone,
	output logic [memPkg::NumCaches-1:0] readValid,
	output memPkg::dataWord_t [memPkg::NumCaches-1:0] readData,
	output logic [memPkg::NumCaches-1:0] writeAdvance,
	output logic [memPkg::NumCaches-1:0] doneRead,
	output logic [memPkg::NumCaches-1:0] doneWrite,
	output logic cmdStart,
	output memPkg::burstCmd_t cmd,
	output memPkg::dataWord_t curWriteData
);
	import memPkg::*;

	typedef enum logic [1:0] {
		Idle,
		Reading,
		Writing
	} state_t;

	state_t state;

	// Round-robin pointer and the cache currently being served
	cacheId_t ptr;
	cacheId_t sel;
	cacheId_t src;

	logic ptrReq;

	assign ptrReq = readReq[ptr] || writeReq[ptr];

	// Start goes out in the same cycle the pointed cache is seen requesting
	assign cmdStart = (state == Idle) && ptrReq;

	always_comb begin
		cmd.isWrite = writeReq[ptr];
		cmd.base = addr[ptr];
		cmd.len = transSize[ptr];
	end

	// While idle the pointed cache is about to be served, so its first word is shown
	assign src = (state == Idle) ? ptr : sel;

	assign curWriteData = writeData[src];

	// Strobes and read data reach only the selected cache
	always_comb begin
		readValid = '0;
		readData = '0;
		writeAdvance = '0;
		if (state == Reading) begin
			readValid[sel] = rdBeat;
			readData[sel] = rdData;
		end
		if (state == Writing) begin
			writeAdvance[sel] = wrTaken;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= Idle;
			ptr <= '0;
			sel <= '0;
			doneRead <= '0;
			doneWrite <= '0;
		end else begin
			// Done pulses last one cycle
			doneRead <= '0;
			doneWrite <= '0;
			case (state)
				Idle: begin
					if (cmdStart) begin
						sel <= ptr;
						state <= writeReq[ptr] ? Writing : Reading;
					end else begin
						ptr <= ptr + 1'b1;
					end
				end
				Reading: begin
					if (burstDone) begin
						doneRead[sel] <= 1'b1;
						ptr <= sel + 1'b1;
						state <= Idle;
					end
				end
				Writing: begin
					if (burstDone) begin
						doneWrite[sel] <= 1'b1;
						ptr <= sel + 1'b1;
						state <= Idle;
					end
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

endmodule

//--- hw/burstEngine.sv
module burstEngine (
	input  logic clk,
	input  logic rst,
	input  logic cmdStart,
	input  memPkg::burstCmd_t cmd,
	input  memPkg::dataWord_t curWriteData,
	input  logic rdValid,
	input  memPkg::dataWord_t storeRdData,
	output logic storeEn,
	output memPkg::storeReq_t storeReq,
	output logic rdBeat,
	output memPkg::dataWord_t rdData,
	output logic wrTaken,
	output logic burstDone
);
	import memPkg::*;

	logic busy;
	logic isWrite;
	logic accept;
	logic issueMore;

	// Issue side counts accesses sent, return side counts read words back
	burstLen_t len;
	burstLen_t issueCnt;
	burstLen_t retCnt;
	wordAddr_t addrCnt;

	assign accept = cmdStart && !busy;
	assign issueMore = busy && (issueCnt < len);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			storeEn <= 1'b0;
			issueCnt <= '0;
			retCnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			storeEn <= 1'b1;
			issueCnt <= 1'b1;
			retCnt <= '0;
		end else begin
			storeEn <= issueMore;
			if (issueMore) begin
				issueCnt <= issueCnt + 1'b1;
			end
			if (rdBeat) begin
				retCnt <= retCnt + 1'b1;
			end
			if (burstDone) begin
				busy <= 1'b0;
			end
		end
	end

	// Access for the next cycle is loaded here, first word straight from the command
	always_ff @(posedge clk) begin
		if (accept) begin
			isWrite <= cmd.isWrite;
			len <= cmd.len;
			addrCnt <= cmd.base + 1'b1;
			storeReq.writeEn <= cmd.isWrite;
			storeReq.addr <= cmd.base;
			storeReq.data <= curWriteData;
		end else if (issueMore) begin
			addrCnt <= addrCnt + 1'b1;
			storeReq.addr <= addrCnt;
			storeReq.data <= curWriteData;
		end
	end

	assign rdBeat = rdValid && busy && !isWrite;
	assign rdData = storeRdData;
	assign wrTaken = storeEn && storeReq.writeEn;

	// Reads finish on the last returned word, not the last issued address
	always_comb begin
		if (isWrite) begin
			burstDone = wrTaken && (issueCnt == len);
		end else begin
			burstDone = rdBeat && (retCnt == len - 1'b1);
		end
	end

endmodule

//--- hw/wordStore.sv
module wordStore (
	input  logic clk,
	input  logic rst,
	input  logic storeEn,
	input  memPkg::storeReq_t storeReq,
	output logic rdValid,
	output memPkg::dataWord_t rdData
);
	import memPkg::*;

	dataWord_t mem [0:(1 << StoreDepthLog)-1];

	// Upper address bits alias onto the low words
	logic [StoreDepthLog-1:0] idx;

	logic [ReadLatency-1:0] validPipe;
	dataWord_t dataPipe [ReadLatency];

	assign idx = storeReq.addr[StoreDepthLog-1:0];

	always_ff @(posedge clk) begin
		if (storeEn && storeReq.writeEn) begin
			mem[idx] <= storeReq.data;
		end
		dataPipe[0] <= mem[idx];
		for (int i = 1; i < ReadLatency; i++) begin
			dataPipe[i] <= dataPipe[i-1];
		end
	end

	// Valid follows the data through the same number of stages
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[ReadLatency-2:0], storeEn && !storeReq.writeEn};
		end
	end

	assign rdValid = validPipe[ReadLatency-1];
	assign rdData = dataPipe[ReadLatency-1];

endmodule

//--- hw/memPkg.sv
package memPkg;

	// Sizes of the shared memory port
	localparam int NumCaches = 4;
	localparam int MaxTrans = 64;
	localparam int ReadLatency = 2;
	localparam int StoreDepthLog = 10;

	typedef logic [24:0] wordAddr_t;
	typedef logic [31:0] dataWord_t;

	// Burst word count, 1 to MaxTrans-1
	typedef logic [$clog2(MaxTrans)-1:0] burstLen_t;
	typedef logic [$clog2(NumCaches)-1:0] cacheId_t;

	// One transaction handed from the arbiter to the burst engine
	typedef struct packed {
		logic isWrite;
		wordAddr_t base;
		burstLen_t len;
	} burstCmd_t;

	// One word access presented to the store
	typedef struct packed {
		logic writeEn;
		wordAddr_t addr;
		dataWord_t data;
	} storeReq_t;

endpackage
